/* include/mem_front_settings.svh */
`ifndef MEM_FRONT_SETTINGS_SVH
`define MEM_FRONT_SETTINGS_SVH

// Address and fetch word width
`define XLEN 32

// One memory block per bus transfer
`define BLOCK_BITS 64

// Reply tag, zero means no tag
`define MEM_TAG_BITS 4

//////////////////////////////
// Instruction cache geometry
//////////////////////////////

`define ICACHE_LINES 32
`define ICACHE_IDX_BITS 5
`define ICACHE_OFFSET_BITS 3   // Byte offset inside a block

// Address bits above index and offset
`define ICACHE_TAG_BITS 24

`endif

/* rtl/icache_ctrl.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module icache_ctrl (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [`XLEN-1:0]             fetch_addr,
    input  logic                         hit,
    input  logic [`MEM_TAG_BITS-1:0]     mem_tag,
    input  logic [`BLOCK_BITS-1:0]       mem_data,
    mem_req_if.client                    req,
    output logic                         fill_en,
    output logic [`ICACHE_IDX_BITS-1:0]  fill_idx,
    output logic [`ICACHE_TAG_BITS-1:0]  fill_tag,
    output logic [`BLOCK_BITS-1:0]       fill_block
);
    import mem_front_pkg::*;

    icache_state_t state;
    icache_state_t next_state;

    logic [`MEM_TAG_BITS-1:0]    saved_tag;   // Tag the reply will carry
    logic [`ICACHE_IDX_BITS-1:0] saved_idx;
    logic [`ICACHE_TAG_BITS-1:0] saved_ctag;

    logic [`ICACHE_IDX_BITS-1:0] miss_idx;
    logic [`ICACHE_TAG_BITS-1:0] miss_ctag;
    logic                        accepted;

    assign miss_idx  = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_IDX_BITS];
    assign miss_ctag = fetch_addr[`XLEN-1 -: `ICACHE_TAG_BITS];

    //////////////////////////////
    // Bus request
    //////////////////////////////

    always_comb begin
        req.command = BUS_NONE;
        if ((state == IC_IDLE) && !hit) begin
            req.command = BUS_LOAD;
        end
    end

    // Block aligned
    assign req.addr = {fetch_addr[`XLEN-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    // Zero response is a reject, retry next cycle
    assign accepted = (state == IC_IDLE) && req.granted && (req.response != '0);

    //////////////////////////////
    // Reply and fill
    //////////////////////////////

    assign fill_en    = (state == IC_WAIT) && (mem_tag != '0) && (mem_tag == saved_tag);
    assign fill_idx   = saved_idx;
    assign fill_tag   = saved_ctag;
    assign fill_block = mem_data;

    always_comb begin
        next_state = state;
        case (state)
            IC_IDLE: begin
                if (accepted) begin
                    next_state = IC_WAIT;
                end
            end
            IC_WAIT: begin
                if (fill_en) begin
                    next_state = IC_IDLE;   // Line written this cycle
                end
            end
            default: next_state = IC_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state     <= IC_IDLE;
            saved_tag <= '0;
        end else begin
            state <= next_state;
            if (accepted) begin
                saved_tag <= req.response;
            end
        end
    end

    // Where the block goes once it returns
    always_ff @(posedge clock) begin
        if (accepted) begin
            saved_idx  <= miss_idx;
            saved_ctag <= miss_ctag;
        end
    end

    a_quiet_in_wait: assert property (@(posedge clock) disable iff (rst)
        (state == IC_WAIT) |-> (req.command == BUS_NONE))
        else $error("icache command while waiting for reply");

    a_tag_held: assert property (@(posedge clock) disable iff (rst)
        (state == IC_WAIT) |-> (saved_tag != '0))
        else $error("icache waiting on a zero tag");

endmodule

/* rtl/icache_store.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module icache_store (
    input  logic                        clock,
    input  logic                        rst,
    input  logic [`XLEN-1:0]            rd_addr,
    output logic                        hit,
    output logic [`XLEN-1:0]            rd_word,
    input  logic                        fill_en,
    input  logic [`ICACHE_IDX_BITS-1:0] fill_idx,
    input  logic [`ICACHE_TAG_BITS-1:0] fill_tag,
    input  logic [`BLOCK_BITS-1:0]      fill_block
);

    logic [`ICACHE_LINES-1:0]                         line_valid;
    logic [`ICACHE_LINES-1:0][`ICACHE_TAG_BITS-1:0]   line_tag;
    logic [`ICACHE_LINES-1:0][`BLOCK_BITS-1:0]        line_data;

    logic [`ICACHE_IDX_BITS-1:0] rd_idx;
    logic [`ICACHE_TAG_BITS-1:0] rd_tag;
    logic                        rd_upper;   // Which half of the block

    assign rd_idx   = rd_addr[`ICACHE_OFFSET_BITS +: `ICACHE_IDX_BITS];
    assign rd_tag   = rd_addr[`XLEN-1 -: `ICACHE_TAG_BITS];
    assign rd_upper = rd_addr[`ICACHE_OFFSET_BITS-1];

    // Lookup
    assign hit     = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
    assign rd_word = rd_upper ? line_data[rd_idx][`XLEN +: `XLEN]
                              : line_data[rd_idx][0 +: `XLEN];

    // Valid bits
    always_ff @(posedge clock) begin
        if (rst) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // Tag and block written together, whole line at once
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= fill_block;
        end
    end

    // Controller must stay quiet while reset holds
    a_no_fill_in_reset: assert property (@(posedge clock) rst |-> !fill_en)
        else $error("icache fill during reset");

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module mem_arbiter (
    mem_req_if.arbiter                    icache,
    input  mem_front_pkg::mem_cmd_t       dcache_command,
    input  logic [`XLEN-1:0]              dcache_addr,
    input  logic [`BLOCK_BITS-1:0]        dcache_wdata,
    input  mem_front_pkg::mem_size_t      dcache_size,
    output logic [`MEM_TAG_BITS-1:0]      dcache_response,
    output logic                          dcache_granted,
    input  logic [`MEM_TAG_BITS-1:0]      mem2cache_response,
    output mem_front_pkg::mem_cmd_t       cache2mem_command,
    output logic [`XLEN-1:0]              cache2mem_addr,
    output logic [`BLOCK_BITS-1:0]        cache2mem_data,
    output mem_front_pkg::mem_size_t      cache2mem_size
);
    import mem_front_pkg::*;

    logic dcache_sel;   // Data port always wins
    logic icache_sel;

    always_comb begin
        dcache_sel = (dcache_command != BUS_NONE);
        icache_sel = !dcache_sel && (icache.command != BUS_NONE);

        //////////////////////////////
        // Bus fields
        //////////////////////////////
        if (dcache_sel) begin
            cache2mem_command = dcache_command;
            cache2mem_addr    = dcache_addr;
            cache2mem_data    = dcache_wdata;
            cache2mem_size    = dcache_size;
        end else begin
            cache2mem_command = icache.command;   // BUS_NONE when icache idle
            cache2mem_addr    = icache.addr;
            cache2mem_data    = '0;
            cache2mem_size    = DOUBLE;           // Fetch is always a full block
        end

        // Acceptance tag goes to the winner only
        dcache_granted  = dcache_sel;
        dcache_response = dcache_sel ? mem2cache_response : '0;
        icache.granted  = icache_sel;
        icache.response = icache_sel ? mem2cache_response : '0;

        // One owner of the bus at a time
        a_one_grant: assert (!(dcache_granted && icache.granted))
            else $error("both cache ports granted");
        a_no_ifetch_store: assert (!(icache.granted && (cache2mem_command == BUS_STORE)))
            else $error("store issued on instruction grant");
    end

endmodule

/* rtl/mem_front.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module mem_front (
    input  logic                         clock,
    input  logic                         rst,

    // Fetch side
    input  logic [`XLEN-1:0]             fetch_addr,
    output logic [`XLEN-1:0]             icache_data,
    output logic                         icache_valid,

    // Data cache requests
    input  mem_front_pkg::mem_cmd_t      dcache_command,
    input  logic [`XLEN-1:0]             dcache_addr,
    input  logic [`BLOCK_BITS-1:0]       dcache_wdata,
    input  mem_front_pkg::mem_size_t     dcache_size,
    output logic [`MEM_TAG_BITS-1:0]     dcache_response,
    output logic                         dcache_granted,

    // Memory
    input  logic [`MEM_TAG_BITS-1:0]     mem2cache_response,  // Acceptance tag
    input  logic [`BLOCK_BITS-1:0]       mem2cache_data,
    input  logic [`MEM_TAG_BITS-1:0]     mem2cache_tag,       // Tag of the reply
    output mem_front_pkg::mem_cmd_t      cache2mem_command,
    output logic [`XLEN-1:0]             cache2mem_addr,
    output logic [`BLOCK_BITS-1:0]       cache2mem_data,
    output mem_front_pkg::mem_size_t     cache2mem_size
);

    mem_req_if icache_req ();

    logic                         fill_en;
    logic [`ICACHE_IDX_BITS-1:0]  fill_idx;
    logic [`ICACHE_TAG_BITS-1:0]  fill_tag;
    logic [`BLOCK_BITS-1:0]       fill_block;

    //////////////////////////////
    // Instruction cache
    //////////////////////////////

    icache_store icache_store_0 (
        .clock      (clock),
        .rst        (rst),
        .rd_addr    (fetch_addr),
        .hit        (icache_valid),   // A hit is a valid fetch
        .rd_word    (icache_data),
        .fill_en    (fill_en),
        .fill_idx   (fill_idx),
        .fill_tag   (fill_tag),
        .fill_block (fill_block)
    );

    icache_ctrl icache_ctrl_0 (
        .clock      (clock),
        .rst        (rst),
        .fetch_addr (fetch_addr),
        .hit        (icache_valid),
        .mem_tag    (mem2cache_tag),
        .mem_data   (mem2cache_data),
        .req        (icache_req.client),
        .fill_en    (fill_en),
        .fill_idx   (fill_idx),
        .fill_tag   (fill_tag),
        .fill_block (fill_block)
    );

    //////////////////////////////
    // Arbiter
    //////////////////////////////

    mem_arbiter mem_arbiter_0 (
        .icache             (icache_req.arbiter),
        .dcache_command     (dcache_command),
        .dcache_addr        (dcache_addr),
        .dcache_wdata       (dcache_wdata),
        .dcache_size        (dcache_size),
        .dcache_response    (dcache_response),
        .dcache_granted     (dcache_granted),
        .mem2cache_response (mem2cache_response),
        .cache2mem_command  (cache2mem_command),
        .cache2mem_addr     (cache2mem_addr),
        .cache2mem_data     (cache2mem_data),
        .cache2mem_size     (cache2mem_size)
    );

endmodule

/* rtl/mem_front_pkg.sv */
package mem_front_pkg;

    //////////////////////////////
    // Memory bus
    //////////////////////////////

    // Command on the shared memory bus
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,   // Idle bus
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } mem_cmd_t;

    // Access size sent with each command
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3       // Full block
    } mem_size_t;

    //////////////////////////////
    // Instruction cache
    //////////////////////////////

    // Miss handling, one fetch in flight at most
    typedef enum logic {
        IC_IDLE = 1'b0,     // May issue a load on a miss
        IC_WAIT = 1'b1      // Load accepted, waiting for the tagged reply
    } icache_state_t;

endpackage

/* rtl/mem_req_if.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

interface mem_req_if;
    import mem_front_pkg::*;

    mem_cmd_t                  command;
    logic [`XLEN-1:0]          addr;
    logic [`MEM_TAG_BITS-1:0]  response;  // Acceptance tag, zero when rejected
    logic                      granted;   // Client owns the bus this cycle

    // Cache side
    modport client (
        output command,
        output addr,
        input  response,
        input  granted
    );

    // Arbiter side
    modport arbiter (
        input  command,
        input  addr,
        output response,
        output granted
    );

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_mem_front -o sim_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qF "*** FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "*** PASSED ***" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0

/* sources.f */
+incdir+include
rtl/mem_front_pkg.sv
rtl/mem_req_if.sv
rtl/icache_store.sv
rtl/icache_ctrl.sv
rtl/mem_arbiter.sv
rtl/mem_front.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_model.sv
testbench/tb_mem_front.sv

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Reset held for two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

/* testbench/tb_mem_front.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module tb_mem_front;
    import mem_front_pkg::*;

    localparam int FETCH_TIMEOUT = 200;

    logic                     clock;
    logic                     rst;
    logic [`XLEN-1:0]         fetch_addr;
    logic [`XLEN-1:0]         icache_data;
    logic                     icache_valid;
    mem_cmd_t                 dcache_command;
    logic [`XLEN-1:0]         dcache_addr;
    logic [`BLOCK_BITS-1:0]   dcache_wdata;
    mem_size_t                dcache_size;
    logic [`MEM_TAG_BITS-1:0] dcache_response;
    logic                     dcache_granted;
    logic [`MEM_TAG_BITS-1:0] mem2cache_response;
    logic [`BLOCK_BITS-1:0]   mem2cache_data;
    logic [`MEM_TAG_BITS-1:0] mem2cache_tag;
    mem_cmd_t                 cache2mem_command;
    logic [`XLEN-1:0]         cache2mem_addr;
    logic [`BLOCK_BITS-1:0]   cache2mem_data;
    mem_size_t                cache2mem_size;

    logic [31:0]              lfsr = 32'h13f1;
    logic [`MEM_TAG_BITS-1:0] pend_tag;   // Instruction load in flight
    int errors = 0;
    int timeouts = 0;
    int rejects = 0;
    int passed = 0;
    int failed = 0;

    // Pairs at 1040 and 2008 share an index
    logic [31:0] pool [8] = '{32'h0000_1040, 32'h0002_1040, 32'h0000_1044, 32'h0000_2008,
                              32'h0003_2008, 32'h0000_30f8, 32'h0001_30fc, 32'h0000_0010};

    tb_clock_gen clk0 (.clock(clock), .rst(rst));

    mem_front dut0 (.*);

    tb_mem_model mem0 (.*);

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Word of a block, inverse address in the upper half
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] blk;
        blk = {a[31:3], 3'b000};
        return a[2] ? ~blk : blk;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if ((errors + timeouts) == errs_before) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: fail", name);
        end
    endtask

    task automatic fetch_block(input logic [31:0] a);
        int n;
        n = 0;
        @(posedge clock);
        fetch_addr <= a;
        @(negedge clock);
        while (!icache_valid && (n < FETCH_TIMEOUT)) begin
            @(negedge clock);
            n++;
        end
        if (!icache_valid) begin
            $display("Timeout while waiting for icache_valid on fetch of %h", a);
            timeouts++;
        end else if (icache_data !== expected_word(a)) begin
            report_mismatch("icache_data", 64'(expected_word(a)), 64'(icache_data));
        end
    endtask

    //////////////////////////////
    // Per-cycle monitor
    //////////////////////////////

    always @(negedge clock) begin
        if (rst) begin
            pend_tag = '0;
        end else begin
            if (dcache_command != BUS_NONE) begin
                if (dcache_granted !== 1'b1)
                    report_mismatch("dcache_granted", 64'd1, 64'(dcache_granted));
                if (cache2mem_command !== dcache_command)
                    report_mismatch("cache2mem_command", 64'(dcache_command),
                                    64'(cache2mem_command));
                if (cache2mem_addr !== dcache_addr)
                    report_mismatch("cache2mem_addr", 64'(dcache_addr), 64'(cache2mem_addr));
                if (cache2mem_data !== dcache_wdata)
                    report_mismatch("cache2mem_data", dcache_wdata, cache2mem_data);
                if (cache2mem_size !== dcache_size)
                    report_mismatch("cache2mem_size", 64'(dcache_size), 64'(cache2mem_size));
                if (dcache_response !== mem2cache_response)
                    report_mismatch("dcache_response", 64'(mem2cache_response),
                                    64'(dcache_response));
            end else begin
                if (dcache_granted !== 1'b0)
                    report_mismatch("dcache_granted", 64'd0, 64'(dcache_granted));
                if (dcache_response !== '0)
                    report_mismatch("dcache_response", 64'd0, 64'(dcache_response));
                if ((cache2mem_command == BUS_LOAD) && (pend_tag != 0)) begin
                    $display("t=%0t instruction load issued while tag %0d outstanding",
                             $time, pend_tag);
                    errors++;
                end
                // Instruction fetch is a full aligned block with no data
                if (cache2mem_command == BUS_LOAD) begin
                    if (cache2mem_addr !== (fetch_addr & 32'hffff_fff8))
                        report_mismatch("cache2mem_addr", 64'(fetch_addr & 32'hffff_fff8),
                                        64'(cache2mem_addr));
                    if (cache2mem_size !== DOUBLE)
                        report_mismatch("cache2mem_size", 64'(DOUBLE), 64'(cache2mem_size));
                    if (cache2mem_data !== '0)
                        report_mismatch("cache2mem_data", 64'd0, cache2mem_data);
                end
                if ((cache2mem_command == BUS_LOAD) && (mem2cache_response == 0)) rejects++;
            end
            if ((pend_tag != 0) && (mem2cache_tag == pend_tag)) begin
                pend_tag = '0;
            end else if ((dcache_command == BUS_NONE) && (cache2mem_command == BUS_LOAD)
                         && (mem2cache_response != 0)) begin
                pend_tag = mem2cache_response;
            end
            if (icache_valid && (icache_data !== expected_word(fetch_addr)))
                report_mismatch("icache_data", 64'(expected_word(fetch_addr)),
                                64'(icache_data));
        end
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    initial begin : stimulus
        int e;
        int n;
        logic [63:0] r;
        fetch_addr     = pool[0];
        dcache_command = BUS_NONE;
        dcache_addr    = '0;
        dcache_wdata   = '0;
        dcache_size    = BYTE;

        // After reset the empty cache asks for the first block
        e = errors + timeouts;
        n = 0;
        @(negedge clock);
        while (rst && (n < 10)) begin
            @(negedge clock);
            n++;
        end
        if (rst) begin
            $display("Reset never released");
            timeouts++;
        end
        if (icache_valid !== 1'b0) report_mismatch("icache_valid", 64'd0, 64'(icache_valid));
        if (cache2mem_command !== BUS_LOAD)
            report_mismatch("cache2mem_command", 64'(BUS_LOAD), 64'(cache2mem_command));
        finish_test("reset", e);

        // Miss, then hits in the same block
        e = errors + timeouts;
        fetch_block(pool[0]);
        @(posedge clock);
        fetch_addr <= pool[2];
        @(negedge clock);
        if (icache_valid !== 1'b1) report_mismatch("icache_valid", 64'd1, 64'(icache_valid));
        if (cache2mem_command !== BUS_NONE)
            report_mismatch("cache2mem_command", 64'(BUS_NONE), 64'(cache2mem_command));
        finish_test("miss_then_hit", e);

        // Retry under rejection, monitor watches for a second load
        e = errors + timeouts;
        for (int i = 0; i < 12; i++) begin
            r = take_bits(3);
            fetch_block(pool[r[2:0]]);
        end
        $display("instruction loads rejected so far: %0d", rejects);
        finish_test("retry", e);

        // Conflicting lines on one index
        e = errors + timeouts;
        fetch_block(pool[0]);
        fetch_block(pool[1]);
        @(posedge clock);
        fetch_addr <= pool[0];
        @(negedge clock);
        if (icache_valid !== 1'b0) report_mismatch("icache_valid", 64'd0, 64'(icache_valid));
        fetch_block(pool[0]);
        finish_test("replace", e);

        // Random data-port traffic against ongoing fetches
        e = errors + timeouts;
        for (int i = 0; i < 80; i++) begin
            @(posedge clock);
            r = take_bits(2);
            dcache_command <= (r[1:0] == 0) ? BUS_NONE : (r[1:0] == 1) ? BUS_LOAD : BUS_STORE;
            dcache_addr    <= 32'(take_bits(32));
            dcache_wdata   <= take_bits(64);
            dcache_size    <= mem_size_t'(2'(take_bits(2)));
            if (take_bits(3) == 0) fetch_addr <= pool[3'(take_bits(3))];
        end
        @(posedge clock);
        dcache_command <= BUS_NONE;
        fetch_block(pool[3]);
        finish_test("dcache_traffic", e);

        $display("tests passed %0d failed %0d errors %0d timeouts %0d",
                 passed, failed, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Whole-run limit
    initial begin
        #400000;
        $display("Simulation ran past its time limit");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/1ps
`include "mem_front_settings.svh"

module tb_mem_model (
    input  logic                          clock,
    input  logic                          rst,
    input  mem_front_pkg::mem_cmd_t       cache2mem_command,
    input  logic [`XLEN-1:0]              cache2mem_addr,
    input  logic [`BLOCK_BITS-1:0]        cache2mem_data,
    input  mem_front_pkg::mem_size_t      cache2mem_size,
    output logic [`MEM_TAG_BITS-1:0]      mem2cache_response,
    output logic [`BLOCK_BITS-1:0]        mem2cache_data,
    output logic [`MEM_TAG_BITS-1:0]      mem2cache_tag
);
    import mem_front_pkg::*;

    logic [31:0]              lfsr;
    logic                     accept_now;     // Drawn one cycle ahead
    logic [15:0]              busy;           // Tags waiting for a reply
    logic [3:0]               wait_cnt [16];
    logic [`XLEN-1:0]         pend_addr [16];
    logic [`MEM_TAG_BITS-1:0] free_tag;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Block address low, its inverse high
    function automatic logic [`BLOCK_BITS-1:0] block_of(input logic [`XLEN-1:0] a);
        logic [`XLEN-1:0] blk;
        blk = {a[`XLEN-1:3], 3'b000};
        return {~blk, blk};
    endfunction

    // Quiet memory side before the first clock edge
    initial begin
        accept_now     = 1'b0;
        mem2cache_tag  = '0;
        mem2cache_data = '0;
    end

    // Lowest free tag, zero when all are in use
    always_comb begin
        free_tag = '0;
        for (int t = 15; t >= 1; t--) begin
            if (!busy[t]) free_tag = 4'(t);
        end
    end

    assign mem2cache_response = ((cache2mem_command != BUS_NONE) && accept_now) ? free_tag : '0;

    //////////////////////////////
    // Replies and bookkeeping
    //////////////////////////////

    always @(posedge clock) begin : model_step
        logic [3:0] done;
        logic       b0;
        logic       b1;
        logic [3:0] delay;
        done = '0;
        if (rst) begin
            lfsr           = 32'h13f1;
            busy          <= '0;
            accept_now    <= 1'b0;
            mem2cache_tag <= '0;
            mem2cache_data <= '0;
        end else begin
            lfsr = lfsr_step(lfsr);
            b0 = lfsr[0];
            lfsr = lfsr_step(lfsr);
            b1 = lfsr[0];
            accept_now <= b0 | b1;   // 3 in 4
            delay = '0;
            for (int i = 0; i < 3; i++) begin
                lfsr = lfsr_step(lfsr);
                delay = {delay[2:0], lfsr[0]};
            end
            for (int t = 1; t < 16; t++) begin
                if (busy[t] && (wait_cnt[t] == 0) && (done == 0)) done = 4'(t);
                if (busy[t] && (wait_cnt[t] != 0)) wait_cnt[t] <= wait_cnt[t] - 4'd1;
            end
            mem2cache_tag  <= done;                 // One reply per cycle
            mem2cache_data <= (done != 0) ? block_of(pend_addr[done]) : '0;
            if (done != 0) busy[done] <= 1'b0;
            if ((cache2mem_command == BUS_LOAD) && (mem2cache_response != 0)) begin
                busy[mem2cache_response]      <= 1'b1;
                wait_cnt[mem2cache_response]  <= delay;   // 1 to 8 cycles
                pend_addr[mem2cache_response] <= cache2mem_addr;
            end
            if ((cache2mem_command == BUS_STORE) && (mem2cache_response != 0)) begin
                $display("store tag %0d addr %h data %h size %0d", mem2cache_response,
                         cache2mem_addr, cache2mem_data, cache2mem_size);
            end
        end
    end

endmodule
